// File: Makefile
# Verilator build and run for the vector engine testbench

VERILATOR	?= verilator
VFLAGS		= --binary --timing --assert -j 0
LINT_FLAGS	= --lint-only --timing --assert
TOP			= vector_engine_tb
FILELIST	= project.f
OBJ_DIR		= obj_dir
PASS_TEXT	= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: common/vector_defines.svh
/*
 * Vector engine sizing
 * Lane count, register file depth, data width and shared memory size
 */
`ifndef VECTOR_DEFINES_SVH
`define VECTOR_DEFINES_SVH

// Lanes and registers per lane
`define NUM_LANES	4
`define NUM_REGS	16

// Datapath width
`define DATA_W		16

// Shared data memory
`define MEM_DEPTH	64
`define ADDR_W		6

`endif

// File: common/vector_pkg.sv
/*
 * Vector engine shared types
 * Word and index widths, command opcodes and the lane FSM encoding
 */
`include "vector_defines.svh"

package vector_pkg;

	// Datapath and index widths
	typedef logic [`DATA_W-1:0]					data_t;
	typedef logic [$clog2(`NUM_REGS)-1:0]		reg_idx_t;
	typedef logic [$clog2(`NUM_LANES)-1:0]		lane_id_t;
	typedef logic [`ADDR_W-1:0]					addr_t;
	typedef logic [`NUM_LANES-1:0]				lane_vec_t;

	// Command opcodes
	typedef enum logic [3:0] {
		OP_SET		= 4'h0,
		OP_ADD		= 4'h1,
		OP_SUB		= 4'h2,
		OP_AND		= 4'h3,
		OP_XOR		= 4'h4,
		OP_LT		= 4'h5,
		OP_LOAD		= 4'h6,
		OP_STORE	= 4'h7,
		OP_READ		= 4'h8
	} op_t;

	// Lane execution FSM
	typedef enum logic [1:0] {
		EX_IDLE		= 2'd0,
		EX_ALU		= 2'd1,
		EX_MEM_REQ	= 2'd2,
		EX_MEM_DATA	= 2'd3
	} exec_state_t;

endpackage

// File: hdl/data_mem.sv
/*
 * Shared data memory
 * Single port, registered read returning the old word on a write
 */
`timescale 1ns/1ps
`include "vector_defines.svh"

module data_mem (
	input	logic					clock,
	input	logic					we,
	input	vector_pkg::addr_t		addr,
	input	vector_pkg::data_t		wdata,
	output	vector_pkg::data_t		rdata
);
	import vector_pkg::*;

	data_t	mem [`MEM_DEPTH];

	always_ff @(posedge clock) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		// Read sees contents before this write
		rdata <= mem[addr];
	end

endmodule

// File: hdl/lane_sequencer.sv
/*
 * Command sequencer
 * Accepts one command while idle, broadcasts it to all lanes,
 * collects lane commits and signals done with the readback word
 */
`timescale 1ns/1ps
`include "vector_defines.svh"

module lane_sequencer (
	input	logic					clock,
	input	logic					reset,
	input	logic					cmd_valid,
	input	vector_pkg::op_t		cmd_op,
	input	vector_pkg::reg_idx_t	cmd_dst,
	input	vector_pkg::reg_idx_t	cmd_src1,
	input	vector_pkg::reg_idx_t	cmd_src2,
	input	vector_pkg::lane_id_t	cmd_lane,
	input	logic					cmd_masked,
	input	vector_pkg::data_t		cmd_scalar,
	input	vector_pkg::lane_vec_t	commit,
	input	vector_pkg::data_t		read_data [`NUM_LANES],
	output	logic					issue,
	output	vector_pkg::op_t		issue_op,
	output	vector_pkg::reg_idx_t	issue_dst,
	output	vector_pkg::reg_idx_t	issue_src1,
	output	vector_pkg::reg_idx_t	issue_src2,
	output	logic					issue_masked,
	output	vector_pkg::data_t		issue_scalar,
	output	logic					busy,
	output	logic					done,
	output	vector_pkg::data_t		result_data
);
	import vector_pkg::*;

	logic		accept;
	lane_id_t	lane_q;
	lane_vec_t	committed;
	lane_vec_t	seen;

	// Strobes during busy are dropped
	assign accept = cmd_valid && !busy;
	assign seen = committed | commit;

	////////////////////////////////////////////////////////////////////////////
	// Control

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			issue <= 1'b0;
			done <= 1'b0;
			committed <= '0;
		end else begin
			issue <= accept;
			done <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				committed <= '0;
			end else if (busy && (seen == '1)) begin
				busy <= 1'b0;
				done <= 1'b1;
				committed <= '0;
			end else if (busy) begin
				committed <= seen;
			end
		end
	end

	// Command fields
	always_ff @(posedge clock) begin
		if (accept) begin
			issue_op		<= cmd_op;
			issue_dst		<= cmd_dst;
			issue_src1		<= cmd_src1;
			issue_src2		<= cmd_src2;
			issue_masked	<= cmd_masked;
			issue_scalar	<= cmd_scalar;
			lane_q			<= cmd_lane;
		end
	end

	assign result_data = read_data[lane_q];

endmodule

// File: hdl/ldst_arbiter.sv
/*
 * Load/store arbiter
 * Round-robin grant of the shared data memory, one lane per cycle
 */
`timescale 1ns/1ps
`include "vector_defines.svh"

module ldst_arbiter (
	input	logic					clock,
	input	logic					reset,
	input	vector_pkg::lane_vec_t	req,
	input	vector_pkg::lane_vec_t	lane_we,
	input	vector_pkg::addr_t		lane_addr [`NUM_LANES],
	input	vector_pkg::data_t		lane_wdata [`NUM_LANES],
	output	vector_pkg::lane_vec_t	grant,
	output	logic					mem_we,
	output	vector_pkg::addr_t		mem_addr,
	output	vector_pkg::data_t		mem_wdata
);
	import vector_pkg::*;

	lane_id_t	last;
	lane_id_t	sel;
	logic		found;

	// Search starts one past the last granted lane
	always_comb begin
		lane_id_t idx;
		sel = last;
		found = 1'b0;
		for (int i = 1; i <= `NUM_LANES; i++) begin
			idx = lane_id_t'(last + i);
			if (!found && req[idx]) begin
				found = 1'b1;
				sel = idx;
			end
		end
	end

	assign grant = found ? (lane_vec_t'(1) << sel) : '0;

	// Memory port follows the selected lane
	assign mem_we = found && lane_we[sel];
	assign mem_addr = lane_addr[sel];
	assign mem_wdata = lane_wdata[sel];

	always_ff @(posedge clock) begin
		if (reset) begin
			last <= lane_id_t'(`NUM_LANES - 1);
		end else if (found) begin
			last <= sel;
		end
	end

endmodule

// File: hdl/vector_engine.sv
/*
 * Vector engine top
 * Sequencer, four lanes, load/store arbiter and shared data memory
 */
`timescale 1ns/1ps
`include "vector_defines.svh"

module vector_engine (
	input	logic					clock,
	input	logic					reset,
	input	logic					cmd_valid,
	input	vector_pkg::op_t		cmd_op,
	input	vector_pkg::reg_idx_t	cmd_dst,
	input	vector_pkg::reg_idx_t	cmd_src1,
	input	vector_pkg::reg_idx_t	cmd_src2,
	input	vector_pkg::lane_id_t	cmd_lane,
	input	logic					cmd_masked,
	input	vector_pkg::data_t		cmd_scalar,
	output	logic					busy,
	output	logic					done,
	output	vector_pkg::data_t		result_data
);
	import vector_pkg::*;

	// Issue broadcast
	logic		issue;
	op_t		issue_op;
	reg_idx_t	issue_dst;
	reg_idx_t	issue_src1;
	reg_idx_t	issue_src2;
	logic		issue_masked;
	data_t		issue_scalar;
	lane_vec_t	commit;
	data_t		read_data [`NUM_LANES];

	// Lane memory requests
	lane_vec_t	mem_req;
	lane_vec_t	mem_grant;
	lane_vec_t	lane_mem_we;
	addr_t		lane_mem_addr [`NUM_LANES];
	data_t		lane_mem_wdata [`NUM_LANES];

	// Memory port
	logic		ram_we;
	addr_t		ram_addr;
	data_t		ram_wdata;
	data_t		ram_rdata;

	lane_sequencer lane_sequencer_i (
		.clock			(clock),
		.reset			(reset),
		.cmd_valid		(cmd_valid),
		.cmd_op			(cmd_op),
		.cmd_dst		(cmd_dst),
		.cmd_src1		(cmd_src1),
		.cmd_src2		(cmd_src2),
		.cmd_lane		(cmd_lane),
		.cmd_masked		(cmd_masked),
		.cmd_scalar		(cmd_scalar),
		.commit			(commit),
		.read_data		(read_data),
		.issue			(issue),
		.issue_op		(issue_op),
		.issue_dst		(issue_dst),
		.issue_src1		(issue_src1),
		.issue_src2		(issue_src2),
		.issue_masked	(issue_masked),
		.issue_scalar	(issue_scalar),
		.busy			(busy),
		.done			(done),
		.result_data	(result_data)
	);

	for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
		lane_unit #(
			.LANE_ID(i)
		) lane_unit_i (
			.clock			(clock),
			.reset			(reset),
			.issue			(issue),
			.issue_op		(issue_op),
			.issue_dst		(issue_dst),
			.issue_src1		(issue_src1),
			.issue_src2		(issue_src2),
			.issue_masked	(issue_masked),
			.issue_scalar	(issue_scalar),
			.mem_grant		(mem_grant[i]),
			.mem_rdata		(ram_rdata),
			.commit			(commit[i]),
			.read_data		(read_data[i]),
			.mem_req		(mem_req[i]),
			.mem_we			(lane_mem_we[i]),
			.mem_addr		(lane_mem_addr[i]),
			.mem_wdata		(lane_mem_wdata[i])
		);
	end

	ldst_arbiter ldst_arbiter_i (
		.clock		(clock),
		.reset		(reset),
		.req		(mem_req),
		.lane_we	(lane_mem_we),
		.lane_addr	(lane_mem_addr),
		.lane_wdata	(lane_mem_wdata),
		.grant		(mem_grant),
		.mem_we		(ram_we),
		.mem_addr	(ram_addr),
		.mem_wdata	(ram_wdata)
	);

	data_mem data_mem_i (
		.clock	(clock),
		.we		(ram_we),
		.addr	(ram_addr),
		.wdata	(ram_wdata),
		.rdata	(ram_rdata)
	);

endmodule

// File: lane/lane_exec.sv
/*
 * Lane execution FSM
 * One-cycle ALU and compare, memory request held until granted,
 * load data taken the cycle after the grant
 */
`timescale 1ns/1ps

module lane_exec (
	input	logic					clock,
	input	logic					reset,
	input	logic					start,
	input	vector_pkg::op_t		op,
	input	logic					active,
	input	vector_pkg::data_t		src_a,
	input	vector_pkg::data_t		src_b,
	input	vector_pkg::data_t		scalar,
	input	vector_pkg::addr_t		addr,
	input	logic					mem_grant,
	input	vector_pkg::data_t		mem_rdata,
	output	logic					wb_en,
	output	logic					wb_mask,
	output	vector_pkg::data_t		wb_data,
	output	logic					commit,
	output	logic					mem_req,
	output	logic					mem_we,
	output	vector_pkg::addr_t		mem_addr,
	output	vector_pkg::data_t		mem_wdata
);
	import vector_pkg::*;

	exec_state_t	state;
	data_t			alu_result;
	logic			is_mem;
	logic			writes_reg;

	assign is_mem = (op == OP_LOAD) || (op == OP_STORE);
	assign writes_reg = (op == OP_SET) || (op == OP_ADD) || (op == OP_SUB) ||
		(op == OP_AND) || (op == OP_XOR);

	always_comb begin
		case (op)
			OP_SET:		alu_result = scalar;
			OP_ADD:		alu_result = src_a + src_b;
			OP_SUB:		alu_result = src_a - src_b;
			OP_AND:		alu_result = src_a & src_b;
			OP_XOR:		alu_result = src_a ^ src_b;
			OP_LT:		alu_result = data_t'(src_a < src_b);
			default:	alu_result = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// State machine and commit pulse

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= EX_IDLE;
			commit <= 1'b0;
		end else begin
			commit <= 1'b0;
			case (state)
				EX_IDLE: begin
					if (start) begin
						state <= EX_ALU;
					end
				end
				EX_ALU: begin
					if (active && is_mem) begin
						state <= EX_MEM_REQ;
					end else if (is_mem) begin
						// Masked-off lane skips the request
						state <= EX_MEM_DATA;
					end else begin
						state <= EX_IDLE;
						commit <= 1'b1;
					end
				end
				EX_MEM_REQ: begin
					// Store completes on the grant edge
					if (mem_grant && (op == OP_STORE)) begin
						state <= EX_IDLE;
						commit <= 1'b1;
					end else if (mem_grant) begin
						state <= EX_MEM_DATA;
					end
				end
				EX_MEM_DATA: begin
					state <= EX_IDLE;
					commit <= 1'b1;
				end
				default: state <= EX_IDLE;
			endcase
		end
	end

	// Write-back, mask update and memory request
	assign wb_en = ((state == EX_ALU) && active && writes_reg) ||
		((state == EX_MEM_DATA) && active);
	assign wb_mask = (state == EX_ALU) && (op == OP_LT);
	assign wb_data = (state == EX_MEM_DATA) ? mem_rdata : alu_result;
	assign mem_req = (state == EX_MEM_REQ);
	assign mem_we = mem_req && (op == OP_STORE);
	assign mem_addr = addr;
	assign mem_wdata = src_b;

endmodule

// File: lane/lane_regfile.sv
/*
 * Lane register file
 * Sixteen words, one synchronous write port and two asynchronous reads
 */
`timescale 1ns/1ps
`include "vector_defines.svh"

module lane_regfile (
	input	logic					clock,
	input	logic					reset,
	input	logic					we,
	input	vector_pkg::reg_idx_t	wr_idx,
	input	vector_pkg::data_t		wr_data,
	input	vector_pkg::reg_idx_t	rd_idx_a,
	input	vector_pkg::reg_idx_t	rd_idx_b,
	output	vector_pkg::data_t		rd_data_a,
	output	vector_pkg::data_t		rd_data_b
);
	import vector_pkg::*;

	data_t	regs [`NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Operand reads, no clock
	assign rd_data_a = regs[rd_idx_a];
	assign rd_data_b = regs[rd_idx_b];

endmodule

// File: lane/lane_unit.sv
/*
 * Lane unit
 * Captures an issued command, reads operands, holds the lane mask,
 * and feeds the execution FSM; write-back goes to registers or mask
 */
`timescale 1ns/1ps
`include "vector_defines.svh"

module lane_unit #(
	parameter int LANE_ID = 0
) (
	input	logic					clock,
	input	logic					reset,
	input	logic					issue,
	input	vector_pkg::op_t		issue_op,
	input	vector_pkg::reg_idx_t	issue_dst,
	input	vector_pkg::reg_idx_t	issue_src1,
	input	vector_pkg::reg_idx_t	issue_src2,
	input	logic					issue_masked,
	input	vector_pkg::data_t		issue_scalar,
	input	logic					mem_grant,
	input	vector_pkg::data_t		mem_rdata,
	output	logic					commit,
	output	vector_pkg::data_t		read_data,
	output	logic					mem_req,
	output	logic					mem_we,
	output	vector_pkg::addr_t		mem_addr,
	output	vector_pkg::data_t		mem_wdata
);
	import vector_pkg::*;

	// Issue capture stage
	logic		s1_valid;
	op_t		s1_op;
	reg_idx_t	s1_dst;
	reg_idx_t	s1_src1;
	reg_idx_t	s1_src2;
	logic		s1_masked;
	data_t		s1_scalar;
	data_t		rd_a;
	data_t		rd_b;
	logic		s1_active;
	addr_t		s1_addr;
	logic		mask_bit;

	// Execute stage
	op_t		ex_op;
	reg_idx_t	ex_dst;
	logic		ex_active;
	data_t		ex_a;
	data_t		ex_b;
	data_t		ex_scalar;
	addr_t		ex_addr;
	logic		wb_en;
	logic		wb_mask;
	data_t		wb_data;

	////////////////////////////////////////////////////////////////////////////
	// Issue capture and operand read

	always_ff @(posedge clock) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= issue;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			s1_op		<= issue_op;
			s1_dst		<= issue_dst;
			s1_src1		<= issue_src1;
			s1_src2		<= issue_src2;
			s1_masked	<= issue_masked;
			s1_scalar	<= issue_scalar;
		end
	end

	lane_regfile lane_regfile_i (
		.clock		(clock),
		.reset		(reset),
		.we			(wb_en),
		.wr_idx		(ex_dst),
		.wr_data	(wb_data),
		.rd_idx_a	(s1_src1),
		.rd_idx_b	(s1_src2),
		.rd_data_a	(rd_a),
		.rd_data_b	(rd_b)
	);

	// Compare and read ignore the mask
	assign s1_active = !s1_masked || mask_bit || (s1_op == OP_LT) || (s1_op == OP_READ);

	// Per-lane address wrapping at memory size
	assign s1_addr = addr_t'(rd_a) + addr_t'(LANE_ID);

	////////////////////////////////////////////////////////////////////////////
	// Execute pipeline register and mask

	always_ff @(posedge clock) begin
		if (s1_valid) begin
			ex_op		<= s1_op;
			ex_dst		<= s1_dst;
			ex_active	<= s1_active;
			ex_a		<= rd_a;
			ex_b		<= rd_b;
			ex_scalar	<= s1_scalar;
			ex_addr		<= s1_addr;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mask_bit <= 1'b1;
		end else if (wb_mask) begin
			mask_bit <= wb_data[0];
		end
	end

	// Last src1 value for scalar readback
	assign read_data = ex_a;

	lane_exec lane_exec_i (
		.clock		(clock),
		.reset		(reset),
		.start		(s1_valid),
		.op			(ex_op),
		.active		(ex_active),
		.src_a		(ex_a),
		.src_b		(ex_b),
		.scalar		(ex_scalar),
		.addr		(ex_addr),
		.mem_grant	(mem_grant),
		.mem_rdata	(mem_rdata),
		.wb_en		(wb_en),
		.wb_mask	(wb_mask),
		.wb_data	(wb_data),
		.commit		(commit),
		.mem_req	(mem_req),
		.mem_we		(mem_we),
		.mem_addr	(mem_addr),
		.mem_wdata	(mem_wdata)
	);

endmodule

// File: project.f
+incdir+common
common/vector_pkg.sv
lane/lane_regfile.sv
lane/lane_exec.sv
lane/lane_unit.sv
hdl/lane_sequencer.sv
hdl/ldst_arbiter.sv
hdl/data_mem.sv
hdl/vector_engine.sv
sim/vector_engine_checker.sv
sim/vector_engine_tb.sv

// File: sim/vector_engine_checker.sv
/*
 * Vector engine protocol checker
 * Concurrent assertions on the done pulse, memory grants and held requests
 */
`timescale 1ns/1ps
`include "vector_defines.svh"

module vector_engine_checker (
	input	logic					clock,
	input	logic					reset,
	input	logic					busy,
	input	logic					done,
	input	vector_pkg::lane_vec_t	mem_req,
	input	vector_pkg::lane_vec_t	mem_grant
);
	import vector_pkg::*;

	lane_vec_t	pending;
	logic		done_bad = 1'b0;
	logic		grant_bad = 1'b0;
	logic		req_bad = 1'b0;
	logic		busy_bad = 1'b0;
	logic		failed;

	// Requests still waiting for their grant
	assign pending = mem_req & ~mem_grant;
	assign failed = done_bad | grant_bad | req_bad | busy_bad;

	done_pulse: assert property (@(posedge clock) disable iff (reset) done |=> !done)
		else begin
			done_bad = 1'b1;
			$error("done stayed high for more than one cycle");
		end

	grant_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(mem_grant))
		else begin
			grant_bad = 1'b1;
			$error("more than one lane granted in the same cycle");
		end

	// A waiting lane keeps its request up
	req_held: assert property (@(posedge clock) disable iff (reset)
		(pending != '0) |=> ((mem_req & $past(pending)) == $past(pending)))
		else begin
			req_bad = 1'b1;
			$error("memory request dropped before its grant");
		end

	done_in_busy: assert property (@(posedge clock) disable iff (reset) done |-> $past(busy))
		else begin
			busy_bad = 1'b1;
			$error("done raised while no command was busy");
		end

endmodule

bind vector_engine vector_engine_checker vector_engine_checker_i (
	.clock		(clock),
	.reset		(reset),
	.busy		(busy),
	.done		(done),
	.mem_req	(mem_req),
	.mem_grant	(mem_grant)
);

// File: sim/vector_engine_tb.sv
/*
 * Vector engine testbench
 * Seeded random commands against a per-lane reference model,
 * with done latency checks and scalar readback of every register
 */
`timescale 1ns/1ps
`include "vector_defines.svh"

module vector_engine_tb;
	import vector_pkg::*;

	localparam int DONE_TIMEOUT = 40;
	localparam int ALU_LATENCY = 4;
	localparam int MEM_MIN_LATENCY = 5;
	localparam int DATA_REGS = 12;
	localparam int TEMP_REG = 12;
	localparam int LOAD_REG = 13;
	localparam int STRAY_REG = 14;
	localparam int BASE_REG = 15;

	logic		clock;
	logic		reset;
	logic		cmd_valid;
	op_t		cmd_op;
	reg_idx_t	cmd_dst;
	reg_idx_t	cmd_src1;
	reg_idx_t	cmd_src2;
	lane_id_t	cmd_lane;
	logic		cmd_masked;
	data_t		cmd_scalar;
	logic		busy;
	logic		done;
	data_t		result_data;

	// Reference model
	data_t		model_regs [`NUM_LANES][`NUM_REGS];
	logic		model_mask [`NUM_LANES];
	data_t		model_mem [`MEM_DEPTH];
	logic		model_written [`MEM_DEPTH];
	data_t		last_result;

	vector_engine vector_engine_i (
		.clock			(clock),
		.reset			(reset),
		.cmd_valid		(cmd_valid),
		.cmd_op			(cmd_op),
		.cmd_dst		(cmd_dst),
		.cmd_src1		(cmd_src1),
		.cmd_src2		(cmd_src2),
		.cmd_lane		(cmd_lane),
		.cmd_masked		(cmd_masked),
		.cmd_scalar		(cmd_scalar),
		.busy			(busy),
		.done			(done),
		.result_data	(result_data)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic int rand_data_reg();
		return int'($urandom_range(0, DATA_REGS - 1));
	endfunction

	function automatic data_t rand_word();
		return data_t'($urandom);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model update for one command over all lanes

	task automatic update_model(input op_t op, input int dst, input int src1, input int src2,
			input logic masked, input data_t scalar);
		logic	active;
		logic	wr;
		data_t	a;
		data_t	b;
		data_t	val;
		int		addr;
		for (int l = 0; l < `NUM_LANES; l++) begin
			a = model_regs[l][src1];
			b = model_regs[l][src2];
			active = !masked || model_mask[l];
			addr = (int'(a) + l) % `MEM_DEPTH;
			wr = 1'b1;
			val = '0;
			case (op)
				OP_SET:	val = scalar;
				OP_ADD:	val = a + b;
				OP_SUB:	val = a - b;
				OP_AND:	val = a & b;
				OP_XOR:	val = a ^ b;
				OP_LOAD: begin
					if (active && !model_written[addr]) begin
						report_failure($sformatf("load from unwritten address %0d", addr));
					end
					val = model_mem[addr];
				end
				OP_STORE: begin
					wr = 1'b0;
					if (active) begin
						model_mem[addr] = b;
						model_written[addr] = 1'b1;
					end
				end
				OP_LT: begin
					wr = 1'b0;
					model_mask[l] = (a < b);
				end
				default: wr = 1'b0;
			endcase
			if (wr && active) begin
				model_regs[l][dst] = val;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Command issue and completion

	// Entered 1 ns after a rising edge; optionally strobes a SET while busy
	task automatic run_cmd(input op_t op, input int dst, input int src1, input int src2,
			input int lane, input logic masked, input data_t scalar, input logic stray);
		int cycles;
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_dst = reg_idx_t'(dst);
		cmd_src1 = reg_idx_t'(src1);
		cmd_src2 = reg_idx_t'(src2);
		cmd_lane = lane_id_t'(lane);
		cmd_masked = masked;
		cmd_scalar = scalar;
		@(posedge clock);
		#1;
		cmd_valid = 1'b0;
		assert (busy) else report_failure($sformatf("command %s was not accepted", op.name()));
		cycles = 0;
		do begin
			@(posedge clock);
			#1;
			cycles++;
			if (stray && cycles == 1) begin
				cmd_valid = 1'b1;
				cmd_op = OP_SET;
				cmd_dst = reg_idx_t'(STRAY_REG);
				cmd_masked = 1'b0;
				cmd_scalar = rand_word() | 16'h0001;
			end else if (stray && cycles == 2) begin
				cmd_valid = 1'b0;
			end
			if (cycles > DONE_TIMEOUT) begin
				report_failure($sformatf("timeout, no done within %0d cycles", DONE_TIMEOUT));
			end
		end while (!done);
		if (op == OP_LOAD || op == OP_STORE) begin
			assert (cycles >= MEM_MIN_LATENCY)
				else report_failure($sformatf("error at %0t: %s done after %0d cycles",
					$time, op.name(), cycles));
		end else begin
			assert (cycles == ALU_LATENCY)
				else report_failure($sformatf("error at %0t: %s done after %0d cycles, expected %0d",
					$time, op.name(), cycles, ALU_LATENCY));
		end
		assert (!busy) else report_failure("busy still high in the done cycle");
		last_result = result_data;
		update_model(op, dst, src1, src2, masked, scalar);
	endtask

	task automatic check_reg(input int idx);
		for (int l = 0; l < `NUM_LANES; l++) begin
			run_cmd(OP_READ, 0, idx, 0, l, 1'b0, '0, 1'b0);
			assert (last_result === model_regs[l][idx])
				else report_failure($sformatf("error at %0t: lane %0d r%0d read 0x%04h, expected 0x%04h",
					$time, l, idx, last_result, model_regs[l][idx]));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequences

	task automatic set_and_read();
		for (int r = 0; r < DATA_REGS; r++) begin
			run_cmd(OP_SET, r, 0, 0, 0, 1'b0, rand_word(), 1'b0);
		end
		for (int r = 0; r < DATA_REGS; r++) begin
			check_reg(r);
		end
	endtask

	// Overlapping stores give each lane its own word at base plus lane
	task automatic spread_lanes();
		data_t base;
		base = data_t'($urandom_range(4, 40));
		for (int k = 0; k < `NUM_LANES; k++) begin
			run_cmd(OP_SET, BASE_REG, 0, 0, 0, 1'b0, base - data_t'(k), 1'b0);
			run_cmd(OP_SET, TEMP_REG, 0, 0, 0, 1'b0, rand_word(), 1'b0);
			run_cmd(OP_STORE, 0, BASE_REG, TEMP_REG, 0, 1'b0, '0, 1'b0);
		end
		run_cmd(OP_SET, BASE_REG, 0, 0, 0, 1'b0, base, 1'b0);
		run_cmd(OP_LOAD, 0, BASE_REG, 0, 0, 1'b0, '0, 1'b0);
		check_reg(0);
	endtask

	task automatic random_alu(input int count);
		op_t op;
		for (int i = 0; i < count; i++) begin
			case ($urandom_range(0, 3))
				0:			op = OP_ADD;
				1:			op = OP_SUB;
				2:			op = OP_AND;
				default:	op = OP_XOR;
			endcase
			run_cmd(op, rand_data_reg(), rand_data_reg(), rand_data_reg(), 0, 1'b0, '0, 1'b0);
		end
		for (int r = 0; r < DATA_REGS; r++) begin
			check_reg(r);
		end
	endtask

	task automatic compare_then_masked_set(input int count);
		int dst;
		for (int i = 0; i < count; i++) begin
			run_cmd(OP_LT, 0, rand_data_reg(), rand_data_reg(), 0, 1'b0, '0, 1'b0);
			dst = rand_data_reg();
			run_cmd(OP_SET, dst, 0, 0, 0, 1'b1, rand_word(), 1'b0);
			check_reg(dst);
		end
	endtask

	task automatic store_then_load();
		int src;
		int dst;
		run_cmd(OP_SET, BASE_REG, 0, 0, 0, 1'b0, data_t'($urandom_range(44, 60)), 1'b0);
		src = rand_data_reg();
		run_cmd(OP_STORE, 0, BASE_REG, src, 0, 1'b0, '0, 1'b0);
		dst = (src + 1 + int'($urandom_range(0, DATA_REGS - 2))) % DATA_REGS;
		run_cmd(OP_LOAD, dst, BASE_REG, 0, 0, 1'b0, '0, 1'b0);
		check_reg(dst);
	endtask

	task automatic masked_store_then_load(input int count);
		for (int i = 0; i < count; i++) begin
			run_cmd(OP_LT, 0, rand_data_reg(), rand_data_reg(), 0, 1'b0, '0, 1'b0);
			run_cmd(OP_SET, TEMP_REG, 0, 0, 0, 1'b0, rand_word(), 1'b0);
			run_cmd(OP_STORE, 0, BASE_REG, TEMP_REG, 0, 1'b1, '0, 1'b1);
			run_cmd(OP_LOAD, LOAD_REG, BASE_REG, 0, 0, 1'b0, '0, 1'b0);
			check_reg(LOAD_REG);
			check_reg(STRAY_REG);
		end
	endtask

	initial begin
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = OP_SET;
		cmd_dst = '0;
		cmd_src1 = '0;
		cmd_src2 = '0;
		cmd_lane = '0;
		cmd_masked = 1'b0;
		cmd_scalar = '0;
		void'($urandom(32'h1bc8));
		for (int l = 0; l < `NUM_LANES; l++) begin
			model_mask[l] = 1'b1;
			for (int r = 0; r < `NUM_REGS; r++) begin
				model_regs[l][r] = '0;
			end
		end
		for (int a = 0; a < `MEM_DEPTH; a++) begin
			model_mem[a] = '0;
			model_written[a] = 1'b0;
		end
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		set_and_read();
		spread_lanes();
		random_alu(40);
		compare_then_masked_set(6);
		store_then_load();
		masked_store_then_load(4);
		for (int r = 0; r < `NUM_REGS; r++) begin
			check_reg(r);
		end

		if (!vector_engine_i.vector_engine_checker_i.failed) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
